// File: build.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/set_array.sv
hdl/cache_control.sv
hdl/flush_engine.sv
hdl/mem_arbiter.sv
hdl/dcache_top.sv
test/dcache_checker.sv
test/tb_dcache.sv

// File: Makefile
# Verilator build and run of the data cache testbench
# make run builds the simulator if a source changed, runs it and checks the log

SIM  = obj_dir/Vtb_dcache
SRCS = build.f $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "TB PASSED" sim.log

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_dcache -Mdir obj_dir -f build.f

clean:
	rm -rf obj_dir sim.log

// File: test/tb_dcache.sv
// testbench for the two-way data cache
// applies a table of cpu reads and writes, each held until dhit,
// then halts the cpu and waits for flushed
// the memory model stretches transfers with a seeded random wait

`include "dcache_defs.svh"

module tb_dcache
	import dcache_pkg::*;
();

	localparam word_t FILL_PAT  = 32'h5ac3_96e1;
	localparam int    WORDS     = 256;
	localparam int    AW        = $clog2(WORDS);
	localparam int    WAIT_PCT  = 40;   // chance of a wait cycle
	localparam int    N_ENTRIES = 14;
	localparam int    MISS_CYC  = 16;   // grant, 4 stretched transfers, fill
	localparam int    FLUSH_CYC = `DC_LINES * 8;
	localparam int    LIMIT     = (N_ENTRIES * MISS_CYC + FLUSH_CYC) * 4;
	localparam logic [1:0] OP_RD   = 2'd0;
	localparam logic [1:0] OP_WR   = 2'd1;
	localparam logic [1:0] OP_HALT = 2'd2;

	logic                  CLK      = 1'b0;
	logic                  mem_wait = 1'b0;
	int                    cycles   = 0;
	logic                  nRST, halt, dmem_ren, dmem_wen, dhit, flushed;
	logic                  mem_ren, mem_wen, exp_valid;
	logic [`DC_ADDR_W-1:0] dmem_addr, mem_addr;
	word_t                 dmem_store, dmem_load, mem_store, mem_load, exp_load;
	int                    tests, errors, n_loaded;
	word_t                 mem_arr [WORDS];

	// stimulus table of operation, address, store data and expected load
	logic [1:0]            t_op   [N_ENTRIES];
	logic [`DC_ADDR_W-1:0] t_addr [N_ENTRIES];
	word_t                 t_data [N_ENTRIES];
	word_t                 t_exp  [N_ENTRIES];

	dcache_top dut (.*);

	dcache_checker #(.FILL_PAT(FILL_PAT), .WORDS(WORDS)) check (.*);

	always #10 CLK = ~CLK;

	// memory model with one word per strobe cycle without wait
	always @(posedge CLK) begin
		if (nRST) begin
			if (mem_wen && !mem_wait)
				mem_arr[mem_addr[`DC_BYTE_W +: AW]] <= mem_store;
			mem_wait <= ($urandom % 100) < WAIT_PCT;
		end
	end

	// data only comes back under the read strobe
	assign mem_load = mem_ren ? mem_arr[mem_addr[`DC_BYTE_W +: AW]] : '0;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run not finished after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic add_entry(input logic [1:0] op, input logic [`DC_ADDR_W-1:0] addr,
		input word_t data, input word_t exp);
		t_op[n_loaded]   = op;
		t_addr[n_loaded] = addr;
		t_data[n_loaded] = data;
		t_exp[n_loaded]  = exp;
		n_loaded++;
	endtask

	// set 0 holds tags 0, 1 and 2 (0x000, 0x040, 0x080)
	task automatic load_table();
		add_entry(OP_RD, 32'h000, '0, 32'h000 ^ FILL_PAT);  // cold miss
		add_entry(OP_RD, 32'h004, '0, 32'h004 ^ FILL_PAT);  // hit on the other word
		add_entry(OP_WR, 32'h004, 32'h1111_0004, '0);
		add_entry(OP_RD, 32'h004, '0, 32'h1111_0004);
		add_entry(OP_RD, 32'h040, '0, 32'h040 ^ FILL_PAT);  // fills way 1
		add_entry(OP_WR, 32'h080, 32'h2222_0080, '0);       // evicts dirty tag 0
		add_entry(OP_RD, 32'h000, '0, 32'h000 ^ FILL_PAT);
		add_entry(OP_RD, 32'h084, '0, 32'h084 ^ FILL_PAT);
		add_entry(OP_WR, 32'h044, 32'h3333_0044, '0);
		add_entry(OP_RD, 32'h004, '0, 32'h1111_0004);       // evicts dirty tag 2
		add_entry(OP_WR, 32'h10c, 32'h4444_010c, '0);       // set 1
		add_entry(OP_RD, 32'h108, '0, 32'h108 ^ FILL_PAT);
		add_entry(OP_RD, 32'h080, '0, 32'h2222_0080);       // evicts dirty tag 1
		add_entry(OP_HALT, '0, '0, '0);
	endtask

	task automatic apply_entry(input int i);
		exp_load  <= t_exp[i];
		exp_valid <= (t_op[i] == OP_RD);
		if (t_op[i] == OP_HALT) begin
			dmem_ren <= 1'b0;
			dmem_wen <= 1'b0;
			halt     <= 1'b1;
			@(posedge CLK);
			while (!flushed)
				@(posedge CLK);
		end else begin
			dmem_ren   <= (t_op[i] == OP_RD);
			dmem_wen   <= (t_op[i] == OP_WR);
			dmem_addr  <= t_addr[i];
			dmem_store <= t_data[i];
			@(posedge CLK);
			while (!dhit)  // request held until the cache answers
				@(posedge CLK);
		end
	endtask

	initial begin
		void'($urandom(32'h90d4477b));
		nRST       = 1'b0;
		halt       = 1'b0;
		dmem_ren   = 1'b0;
		dmem_wen   = 1'b0;
		dmem_addr  = '0;
		dmem_store = '0;
		exp_load   = '0;
		exp_valid  = 1'b0;
		n_loaded   = 0;
		for (int w = 0; w < WORDS; w++)
			mem_arr[w] = word_t'(w << `DC_BYTE_W) ^ FILL_PAT;
		load_table();
		repeat (3) @(posedge CLK);
		nRST <= 1'b1;
		@(posedge CLK);
		for (int i = 0; i < n_loaded; i++)
			apply_entry(i);
		repeat (4) @(posedge CLK);  // bus must stay quiet after flushed
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: test/dcache_checker.sv
// checker for the data cache testbench
// keeps a shadow memory from the cpu writes and a mirror of the bus writes,
// compares loads and bus writes, then checks the flush result
// tests and errors are read by the testbench top for the final verdict

`include "dcache_defs.svh"

module dcache_checker
	import dcache_pkg::*;
#(
	parameter word_t FILL_PAT = '0,
	parameter int    WORDS    = 256
) (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  dmem_ren,
	input  logic                  dmem_wen,
	input  logic [`DC_ADDR_W-1:0] dmem_addr,
	input  word_t                 dmem_store,
	input  word_t                 dmem_load,
	input  logic                  dhit,
	input  logic                  flushed,
	input  logic                  mem_ren,
	input  logic                  mem_wen,
	input  logic [`DC_ADDR_W-1:0] mem_addr,
	input  word_t                 mem_store,
	input  logic                  mem_wait,
	input  word_t                 exp_load,
	input  logic                  exp_valid,
	output int                    tests,
	output int                    errors
);

	localparam int AW = $clog2(WORDS);

	word_t shadow [WORDS];
	word_t mirror [WORDS];   // what the bus actually wrote
	logic  written [WORDS];
	logic  flushed_q  = 1'b0;
	logic  reset_seen = 1'b0;
	int    n_tests    = 0;
	int    n_errors   = 0;

	assign tests  = n_tests;
	assign errors = n_errors;

	// memory content before any write
	function automatic word_t initial_word(input int w);
		return word_t'(w << `DC_BYTE_W) ^ FILL_PAT;
	endfunction

	task automatic report_mismatch(input string name, input word_t want, input word_t got);
		$display("ERROR %0t: %s expected %h got %h", $time, name, want, got);
		n_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("%0t: %s", $time, what);
		n_errors++;
	endtask

	task automatic finish_test(input string name, input int e0);
		n_tests++;
		$display("test %0d: %s %s", n_tests, name, (n_errors == e0) ? "ok" : "failed");
	endtask

	task automatic check_reset_state();
		int e0;
		e0 = n_errors;
		if (dhit !== 1'b0)
			report_mismatch("dhit", '0, word_t'(dhit));
		if (flushed !== 1'b0)
			report_mismatch("flushed", '0, word_t'(flushed));
		if (mem_ren !== 1'b0)
			report_mismatch("mem_ren", '0, word_t'(mem_ren));
		if (mem_wen !== 1'b0)
			report_mismatch("mem_wen", '0, word_t'(mem_wen));
		reset_seen = 1'b1;
		finish_test("reset state", e0);
	endtask

	task automatic check_access();
		logic [AW-1:0] w;
		int            e0;
		w  = dmem_addr[`DC_BYTE_W +: AW];
		e0 = n_errors;
		if (dmem_wen) begin
			shadow[w] = dmem_store;  // write lands in the cache here
		end else begin
			if (exp_valid && exp_load !== shadow[w])
				report_failure("table value does not follow the memory rules");
			if (dmem_load !== shadow[w])
				report_mismatch("dmem_load", shadow[w], dmem_load);
		end
		finish_test($sformatf("%s %h", dmem_wen ? "write" : "read", dmem_addr), e0);
	endtask

	// evicted or flushed words must carry the latest cpu value
	task automatic check_bus_write();
		logic [AW-1:0] w;
		w = mem_addr[`DC_BYTE_W +: AW];
		if (mem_store !== shadow[w])
			report_mismatch("mem_store", shadow[w], mem_store);
		mirror[w]  = mem_store;
		written[w] = 1'b1;
	endtask

	task automatic check_flush();
		int e0;
		e0 = n_errors;
		for (int w = 0; w < WORDS; w++) begin
			if (shadow[w] !== initial_word(w) && (!written[w] || mirror[w] !== shadow[w]))
				report_failure($sformatf("word at %h was not written back", w << `DC_BYTE_W));
		end
		finish_test("flush", e0);
	endtask

	// sample at the falling edge, all inputs settled
	always @(negedge CLK) begin
		if (!nRST) begin
			for (int w = 0; w < WORDS; w++) begin
				shadow[w]  = initial_word(w);
				written[w] = 1'b0;
			end
		end else begin
			if (!reset_seen)
				check_reset_state();
			if (dhit && (dmem_ren || dmem_wen))
				check_access();
			if (mem_wen && !mem_wait)
				check_bus_write();
			if (flushed && (mem_ren || mem_wen))
				report_failure("memory strobe seen after flushed");
			if (flushed && !flushed_q)
				check_flush();
			flushed_q = flushed;
		end
	end

endmodule

// File: hdl/dcache_top.sv
// data cache top level
// cpu side: level requests held until dhit, halt starts the flush
// memory side: one word per strobe cycle with mem_wait low

`include "dcache_defs.svh"

module dcache_top
	import dcache_pkg::*;
(
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  halt,
	input  logic                  dmem_ren,
	input  logic                  dmem_wen,
	input  logic [`DC_ADDR_W-1:0] dmem_addr,
	input  word_t                 dmem_store,
	output word_t                 dmem_load,
	output logic                  dhit,
	output logic                  flushed,
	output logic                  mem_ren,
	output logic                  mem_wen,
	output logic [`DC_ADDR_W-1:0] mem_addr,
	output word_t                 mem_store,
	input  word_t                 mem_load,
	input  logic                  mem_wait
);

	logic [`DC_IDX_W-1:0]  rd_idx_a, rd_idx_b, wr_idx;
	tag_entry_t            tag_a0, tag_a1, tag_b0, tag_b1, tag_wr_data;
	block_t                data_a0, data_a1, data_b0, data_b1, data_wr_data;
	logic                  tag_wr_en, data_wr_en, wr_way;
	logic                  miss_req, miss_ren, miss_wen, miss_wait;
	logic [`DC_ADDR_W-1:0] miss_addr, flush_addr;
	word_t                 miss_store, flush_store;
	logic                  flush_req, flush_ren, flush_wen, flush_wait;

	set_array #(.entry_t(tag_entry_t)) tag_store (
		.CLK, .nRST, .rd_idx_a, .rd_idx_b,
		.wr_en(tag_wr_en), .wr_idx, .wr_way, .wr_data(tag_wr_data),
		.rd_a0(tag_a0), .rd_a1(tag_a1), .rd_b0(tag_b0), .rd_b1(tag_b1)
	);

	set_array #(.entry_t(block_t)) data_store (
		.CLK, .nRST, .rd_idx_a, .rd_idx_b,
		.wr_en(data_wr_en), .wr_idx, .wr_way, .wr_data(data_wr_data),
		.rd_a0(data_a0), .rd_a1(data_a1), .rd_b0(data_b0), .rd_b1(data_b1)
	);

	cache_control ctrl (
		.CLK, .nRST, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store,
		.tag_a0, .tag_a1, .data_a0, .data_a1, .mem_load, .miss_wait,
		.dmem_load, .dhit, .rd_idx(rd_idx_a),
		.tag_wr_en, .tag_wr_data, .data_wr_en, .data_wr_data, .wr_idx, .wr_way,
		.miss_req, .miss_ren, .miss_wen, .miss_addr, .miss_store
	);

	flush_engine flush (
		.CLK, .nRST, .halt, .tag_b0, .tag_b1, .data_b0, .data_b1, .flush_wait,
		.rd_idx(rd_idx_b), .flush_req, .flush_ren, .flush_wen,
		.flush_addr, .flush_store, .flushed
	);

	mem_arbiter arb (
		.CLK, .nRST,
		.miss_req, .miss_ren, .miss_wen, .miss_addr, .miss_store,
		.flush_req, .flush_ren, .flush_wen, .flush_addr, .flush_store,
		.miss_wait, .flush_wait,
		.mem_ren, .mem_wen, .mem_addr, .mem_store, .mem_wait
	);

endmodule

// File: hdl/mem_arbiter.sv
// shares the one memory port between the miss engine and the flush walker
// the owner is registered and the miss side wins a tie
// a grant is held while its req stays up
// the side without the grant sees wait high

`include "dcache_defs.svh"

module mem_arbiter (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  miss_req,
	input  logic                  miss_ren,
	input  logic                  miss_wen,
	input  logic [`DC_ADDR_W-1:0] miss_addr,
	input  logic [`DC_WORD_W-1:0] miss_store,
	input  logic                  flush_req,
	input  logic                  flush_ren,
	input  logic                  flush_wen,
	input  logic [`DC_ADDR_W-1:0] flush_addr,
	input  logic [`DC_WORD_W-1:0] flush_store,
	output logic                  miss_wait,
	output logic                  flush_wait,
	output logic                  mem_ren,
	output logic                  mem_wen,
	output logic [`DC_ADDR_W-1:0] mem_addr,
	output logic [`DC_WORD_W-1:0] mem_store,
	input  logic                  mem_wait
);

	logic own_miss, own_flush;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			own_miss  <= 1'b0;
			own_flush <= 1'b0;
		end else if (own_miss || own_flush) begin
			own_miss  <= own_miss && miss_req;  // release when req drops
			own_flush <= own_flush && flush_req;
		end else begin
			own_miss  <= miss_req;
			own_flush <= flush_req && !miss_req;
		end
	end

	assign mem_ren    = (own_miss && miss_ren) || (own_flush && flush_ren);
	assign mem_wen    = (own_miss && miss_wen) || (own_flush && flush_wen);
	assign mem_addr   = own_flush ? flush_addr : miss_addr;
	assign mem_store  = own_flush ? flush_store : miss_store;
	assign miss_wait  = own_miss ? mem_wait : 1'b1;
	assign flush_wait = own_flush ? mem_wait : 1'b1;

	// two grants at once would let the other side's strobes onto the bus
	a_one_owner: assert property (@(posedge CLK) disable iff (!nRST)
		!(own_miss && own_flush));

endmodule

// File: hdl/flush_engine.sv
// writes every dirty line back to memory once the cpu halts
// walks set and way with a line counter through read port B,
// then holds flushed high until reset

`include "dcache_defs.svh"

module flush_engine
	import dcache_pkg::*;
(
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  halt,
	input  tag_entry_t            tag_b0,
	input  tag_entry_t            tag_b1,
	input  block_t                data_b0,
	input  block_t                data_b1,
	input  logic                  flush_wait,
	output logic [`DC_IDX_W-1:0]  rd_idx,
	output logic                  flush_req,
	output logic                  flush_ren,
	output logic                  flush_wen,
	output logic [`DC_ADDR_W-1:0] flush_addr,
	output word_t                 flush_store,
	output logic                  flushed
);

	typedef enum logic [1:0] {F_IDLE, F_LINE, F_WORD1, F_DONE} fstate_t;

	fstate_t                      state;
	logic [$clog2(`DC_LINES)-1:0] line;  // msb is the way
	tag_entry_t                   ltag;
	block_t                       ldata;
	logic                         dirty, last;

	assign rd_idx = line[`DC_IDX_W-1:0];
	assign ltag   = line[$high(line)] ? tag_b1 : tag_b0;
	assign ldata  = line[$high(line)] ? data_b1 : data_b0;
	assign dirty  = ltag.valid && ltag.dirty;
	assign last   = (line == `DC_LINES - 1);

	assign flush_req   = (state == F_LINE && dirty) || state == F_WORD1;
	assign flush_wen   = flush_req;
	assign flush_ren   = 1'b0;  // write-only walker
	assign flush_addr  = word_addr(ltag.tag, rd_idx, state == F_WORD1);
	assign flush_store = ldata[state == F_WORD1];
	assign flushed     = (state == F_DONE);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= F_IDLE;
			line  <= '0;
		end else begin
			case (state)
				F_IDLE: if (halt) state <= F_LINE;
				F_LINE: begin
					if (dirty) begin
						if (!flush_wait) state <= F_WORD1;
					end else if (last) begin
						state <= F_DONE;
					end else begin
						line <= line + 1'b1;  // clean line, one cycle
					end
				end
				F_WORD1: begin
					if (!flush_wait) begin
						state <= last ? F_DONE : F_LINE;
						if (!last) line <= line + 1'b1;
					end
				end
				default: state <= F_DONE;  // done is sticky
			endcase
		end
	end

	a_quiet_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed && !flush_req);

endmodule

// File: hdl/cache_control.sv
// hit lookup and miss handling for the data cache
// hits answer in the same cycle; a miss writes back a dirty victim,
// fetches both words of the new block and answers in the FILL cycle
// owns read port A and the write port of both set arrays

`include "dcache_defs.svh"

module cache_control
	import dcache_pkg::*;
(
	input  logic                 CLK,
	input  logic                 nRST,
	input  logic                 dmem_ren,
	input  logic                 dmem_wen,
	input  logic [`DC_ADDR_W-1:0] dmem_addr,
	input  word_t                dmem_store,
	input  tag_entry_t           tag_a0,
	input  tag_entry_t           tag_a1,
	input  block_t               data_a0,
	input  block_t               data_a1,
	input  word_t                mem_load,
	input  logic                 miss_wait,
	output word_t                dmem_load,
	output logic                 dhit,
	output logic [`DC_IDX_W-1:0] rd_idx,
	output logic                 tag_wr_en,
	output tag_entry_t           tag_wr_data,
	output logic                 data_wr_en,
	output block_t               data_wr_data,
	output logic [`DC_IDX_W-1:0] wr_idx,
	output logic                 wr_way,
	output logic                 miss_req,
	output logic                 miss_ren,
	output logic                 miss_wen,
	output logic [`DC_ADDR_W-1:0] miss_addr,
	output word_t                miss_store
);

	typedef enum logic [2:0] {IDLE, WB0, WB1, FETCH0, FETCH1, FILL} state_t;

	state_t              state, next_state;
	dc_addr_t            a;
	logic [`DC_SETS-1:0] lru;        // 1 = way 1 used last
	logic                vway;       // victim, latched while idle
	logic                vway_pick;
	logic                req, hit0, hit1, hit;
	tag_entry_t          htag, ptag, vtag;
	block_t              hdata, vdata;

	assign a    = dc_addr_t'(dmem_addr);
	assign req  = dmem_ren | dmem_wen;
	assign hit0 = tag_a0.valid && (tag_a0.tag == a.tag);
	assign hit1 = tag_a1.valid && (tag_a1.tag == a.tag);
	assign hit  = hit0 | hit1;

	assign htag  = hit1 ? tag_a1 : tag_a0;
	assign hdata = hit1 ? data_a1 : data_a0;
	assign ptag  = vway_pick ? tag_a1 : tag_a0;
	assign vtag  = vway ? tag_a1 : tag_a0;
	assign vdata = vway ? data_a1 : data_a0;

	// empty way first, else the one not used last
	always_comb begin
		if (!tag_a0.valid)
			vway_pick = 1'b0;
		else if (!tag_a1.valid)
			vway_pick = 1'b1;
		else
			vway_pick = ~lru[a.idx];
	end

	// cpu holds its address through a miss, so one index serves all
	assign rd_idx   = a.idx;
	assign wr_idx   = a.idx;
	assign miss_req = state inside {WB0, WB1, FETCH0, FETCH1};

	always_comb begin
		next_state   = state;
		dhit         = 1'b0;
		dmem_load    = hdata[a.blkoff];
		tag_wr_en    = 1'b0;
		tag_wr_data  = vtag;
		data_wr_en   = 1'b0;
		data_wr_data = vdata;
		wr_way       = vway;
		miss_ren     = 1'b0;
		miss_wen     = 1'b0;
		miss_addr    = word_addr(a.tag, a.idx, 1'b0);
		miss_store   = '0;
		case (state)
			IDLE: begin
				wr_way = hit1;
				if (req && hit) begin
					dhit = 1'b1;
					if (dmem_wen) begin  // merge store, mark dirty
						tag_wr_en          = 1'b1;
						tag_wr_data        = htag;
						tag_wr_data.dirty  = 1'b1;
						data_wr_en         = 1'b1;
						data_wr_data       = hdata;
						data_wr_data[a.blkoff] = dmem_store;
					end
				end else if (req) begin
					next_state = (ptag.valid && ptag.dirty) ? WB0 : FETCH0;
				end
			end
			WB0, WB1: begin
				miss_wen   = 1'b1;
				miss_addr  = word_addr(vtag.tag, a.idx, state == WB1);
				miss_store = vdata[state == WB1];
				if (!miss_wait)
					next_state = (state == WB0) ? WB1 : FETCH0;
			end
			FETCH0: begin
				miss_ren = 1'b1;
				if (!miss_wait) begin
					data_wr_en      = 1'b1;
					data_wr_data[0] = mem_load;
					tag_wr_en       = 1'b1;  // new tag, not valid until fill
					tag_wr_data     = '{tag: a.tag, valid: 1'b0, dirty: 1'b0};
					next_state      = FETCH1;
				end
			end
			FETCH1: begin
				miss_ren  = 1'b1;
				miss_addr = word_addr(a.tag, a.idx, 1'b1);
				if (!miss_wait) begin
					data_wr_en      = 1'b1;
					data_wr_data[1] = mem_load;
					next_state      = FILL;
				end
			end
			FILL: begin
				dhit        = 1'b1;
				dmem_load   = vdata[a.blkoff];
				tag_wr_en   = 1'b1;
				tag_wr_data = '{tag: a.tag, valid: 1'b1, dirty: dmem_wen};
				if (dmem_wen) begin
					data_wr_en             = 1'b1;
					data_wr_data[a.blkoff] = dmem_store;
				end
				next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			vway  <= 1'b0;
			lru   <= '0;
		end else begin
			state <= next_state;
			if (state == IDLE)
				vway <= vway_pick;
			if (state == IDLE && req && hit)
				lru[a.idx] <= hit1;
			else if (state == FILL)
				lru[a.idx] <= vway;
		end
	end

	a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
		!(miss_ren && miss_wen));

	// back-pressure keeps the request steady into the next cycle
	a_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
		(miss_ren || miss_wen) && miss_wait |=>
			$stable(miss_addr) && $stable({miss_ren, miss_wen}));

endmodule

// File: hdl/set_array.sv
// per-set, per-way storage used for both the tag store and the data store
// two combinational read ports, each giving both ways of one set
// one write port, the write lands at the next clock edge

`include "dcache_defs.svh"

module set_array
	import dcache_pkg::*;
#(
	parameter type entry_t = tag_entry_t
) (
	input  logic                 CLK,
	input  logic                 nRST,
	input  logic [`DC_IDX_W-1:0] rd_idx_a,
	input  logic [`DC_IDX_W-1:0] rd_idx_b,
	input  logic                 wr_en,
	input  logic [`DC_IDX_W-1:0] wr_idx,
	input  logic                 wr_way,
	input  entry_t               wr_data,
	output entry_t               rd_a0,
	output entry_t               rd_a1,
	output entry_t               rd_b0,
	output entry_t               rd_b1
);

	entry_t mem [`DC_SETS][2];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				mem[s][0] <= '0;
				mem[s][1] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_idx][wr_way] <= wr_data;
		end
	end

	// port a, controller side
	assign rd_a0 = mem[rd_idx_a][0];
	assign rd_a1 = mem[rd_idx_a][1];

	// port b, flush walker
	assign rd_b0 = mem[rd_idx_b][0];
	assign rd_b1 = mem[rd_idx_b][1];

endmodule

// File: hdl/dcache_pkg.sv
// types shared by the data cache blocks
// modules take them with a wildcard import in their header

`include "dcache_defs.svh"

package dcache_pkg;

	typedef logic [`DC_WORD_W-1:0] word_t;

	// cpu address split into its cache fields
	typedef struct packed {
		logic [`DC_TAG_W-1:0]  tag;
		logic [`DC_IDX_W-1:0]  idx;
		logic                  blkoff;  // word within block
		logic [`DC_BYTE_W-1:0] bytoff;
	} dc_addr_t;

	// tag store entry, 28 bits
	typedef struct packed {
		logic [`DC_TAG_W-1:0] tag;
		logic                 valid;
		logic                 dirty;
	} tag_entry_t;

	typedef word_t [1:0] block_t;  // word 0 in the low half

	// memory address of one word of a block
	function automatic logic [`DC_ADDR_W-1:0] word_addr(input logic [`DC_TAG_W-1:0] tag,
		input logic [`DC_IDX_W-1:0] idx, input logic off);
		return {tag, idx, off, {`DC_BYTE_W{1'b0}}};
	endfunction

endpackage

// File: hdl/dcache_defs.svh
// geometry of the two-way write-back data cache
// include in every RTL file that needs a width or a count
// 8 sets x 2 ways x 2 words, word accesses only

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// data and address
`define DC_WORD_W 32
`define DC_ADDR_W 32

// sets and the index into them
`define DC_SETS   8
`define DC_IDX_W  3

// address fields, tag + index + 1 block offset bit + byte offset
`define DC_TAG_W  26
`define DC_BYTE_W 2

// one flush step per set and way
`define DC_LINES  16

`endif
